/* vlog.f */
+incdir+hdl
hdl/uartRegPkg.sv
hdl/uartLinePkg.sv
hdl/uartRegFile.sv
hdl/uartBaudGen.sv
hdl/uartTx.sv
hdl/uartRx.sv
hdl/uartTop.sv
bench/uartTb.sv

/* Makefile */
# Verilator build and run of the UART testbench
TOP := uartTb

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

/* bench/uartTb.sv */
// UART testbench. Runs with prescale 0 and divisor 2, so one serial bit is 32 PCLK cycles.
// The rx FIFO head and count are probed inside the DUT by hierarchical name.
`timescale 1ns/100ps
`include "uartDefs_defs.svh"

module uartTb;

  localparam realtime DriveDly  = 0.5;                       // after the rising edge
  localparam int      Divisor   = 2;
  localparam int      BitCycles = Divisor * `UART_OVERSAMPLE;
  localparam int      WaitLimit = 4000;                      // cycles or polls per wait

  logic                PCLK;
  logic                PRESETn;
  uartRegPkg::regAddrT addr;
  uartRegPkg::regByteT din, dout;
  logic                memRdb, memWrb, intr, sin, sout;

  integer seed = 60587;
  int     errors = 0;
  int     checks = 0;
  int     testNum = 0;
  int     testErrBase = 0;
  logic   hung = 1'b0;
  logic   allDone = 1'b0;

  uartTop i_dut (.PCLK, .PRESETn, .addr, .din, .dout, .memRdb, .memWrb, .intr, .sin, .sout);

  initial PCLK = 1'b0;
  always #2 PCLK = ~PCLK;                                    // 4 ns period

  //////////////////// reference model
  function automatic int dataBits(uartLinePkg::frameCfgT cfg);
    return 5 + int'(cfg.wordLen);
  endfunction

  function automatic int frameLen(uartLinePkg::frameCfgT cfg);
    return 1 + dataBits(cfg) + int'(cfg.parityEn) + 1 + int'(cfg.twoStop);
  endfunction

  // line bits lsb first: start, data, parity, stop(s), idle ones above
  function automatic logic [11:0] frameBits(uartLinePkg::frameCfgT cfg, logic [7:0] value);
    logic [11:0] bits;
    logic [7:0]  d;
    int          i;
    d       = value & 8'((1 << dataBits(cfg)) - 1);
    bits    = '1;
    bits[0] = 1'b0;
    for (i = 0; i < dataBits(cfg); i++) bits[i+1] = d[i];
    if (cfg.parityEn) bits[dataBits(cfg) + 1] = cfg.evenParity ? ^d : ~^d;
    return bits;
  endfunction

  function automatic uartLinePkg::rxEntryT expectRx(uartLinePkg::frameCfgT cfg,
      logic [7:0] value, logic badParity, logic badStop);
    uartLinePkg::rxEntryT e;
    e.overrun    = 1'b0;                                     // stored entries never carry it
    e.parityErr  = cfg.parityEn && badParity;
    e.framingErr = badStop;
    e.data       = value & 8'((1 << dataBits(cfg)) - 1);
    return e;
  endfunction

  function automatic uartRegPkg::regByteT lcrOf(uartLinePkg::frameCfgT cfg, logic dlab);
    uartRegPkg::lcrT l;
    l            = '0;
    l.dlab       = dlab;
    l.evenParity = cfg.evenParity;
    l.parityEn   = cfg.parityEn;
    l.twoStop    = cfg.twoStop;
    l.wordLen    = cfg.wordLen;
    return l;
  endfunction

  // transmitter idle in every use, so temt and thre are set
  function automatic uartRegPkg::regByteT lsrExpect(logic fifoErr, logic fe, logic pe,
      logic oe, logic dr);
    uartRegPkg::lsrT l;
    l            = '0;
    l.fifoErr    = fifoErr;
    l.temt       = 1'b1;
    l.thre       = 1'b1;
    l.framingErr = fe;
    l.parityErr  = pe;
    l.overrunErr = oe;
    l.dataReady  = dr;
    return l;
  endfunction

  //////////////////// compare tasks
  task automatic checkByte(input string name, input uartRegPkg::regByteT got,
                           input uartRegPkg::regByteT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %02h, expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic checkEntry(input string name, input uartLinePkg::rxEntryT got,
                            input uartLinePkg::rxEntryT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %03h, expected %03h", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic endTest(input string name);
    testNum++;
    if (errors == testErrBase) $display("test %0d %s: ok", testNum, name);
    else $display("test %0d %s: %0d errors", testNum, name, errors - testErrBase);
    testErrBase = errors;
  endtask

  // stalls the caller for good, the finisher ends the run
  task automatic giveUp(input string what);
    $display("timeout at %0t: %s never happened", $time, what);
    hung = 1'b1;
    forever @(posedge PCLK);
  endtask

  //////////////////// bus
  task automatic writeReg(input uartRegPkg::regAddrT a, input uartRegPkg::regByteT data);
    @(posedge PCLK);
    #(DriveDly);
    addr   = a;
    din    = data;
    memWrb = 1'b0;
    @(posedge PCLK);                                         // write lands here
    #(DriveDly);
    memWrb = 1'b1;
  endtask

  task automatic readReg(input uartRegPkg::regAddrT a, output uartRegPkg::regByteT data);
    @(posedge PCLK);
    #(DriveDly);
    addr   = a;
    memRdb = 1'b0;
    @(negedge PCLK);
    data = dout;                                             // stable mid-cycle
    @(posedge PCLK);
    #(DriveDly);
    memRdb = 1'b1;
  endtask

  task automatic expectReg(input uartRegPkg::regAddrT a, input uartRegPkg::regByteT exp);
    uartRegPkg::regByteT val;
    readReg(a, val);
    checkByte(a.name(), val, exp);
  endtask

  // one rbr read, checks the fifo head entry and the byte on the bus
  task automatic popEntry(input uartLinePkg::rxEntryT exp);
    uartLinePkg::rxEntryT head;
    uartRegPkg::regByteT  data;
    @(posedge PCLK);
    #(DriveDly);
    addr   = uartRegPkg::regRbr;
    memRdb = 1'b0;
    @(negedge PCLK);
    head = i_dut.rxHead;
    data = dout;
    @(posedge PCLK);
    #(DriveDly);
    memRdb = 1'b1;
    checkEntry("rx fifo head", head, exp);
    checkByte("rbr", data, exp.data);
  endtask

  task automatic setFormat(input uartLinePkg::frameCfgT cfg);
    writeReg(uartRegPkg::regLcr, lcrOf(cfg, 1'b1));
    writeReg(uartRegPkg::regRbr, 8'(Divisor));               // dll
    writeReg(uartRegPkg::regIer, 8'h00);                     // dlm
    writeReg(uartRegPkg::regLcr, lcrOf(cfg, 1'b0));
  endtask

  //////////////////// bounded waits
  task automatic waitLsrBit(input int idx, input string what);
    uartRegPkg::regByteT val;
    int n;
    n = 0;
    readReg(uartRegPkg::regLsr, val);
    while (!val[idx]) begin
      n++;
      if (n > WaitLimit) giveUp(what);
      readReg(uartRegPkg::regLsr, val);
    end
  endtask

  task automatic waitRxCount(input int cnt);
    int n;
    n = 0;
    @(negedge PCLK);
    while (i_dut.rxCount != uartLinePkg::fifoCountT'(cnt)) begin
      n++;
      if (n > WaitLimit) giveUp("rx fifo count reaching its target");
      @(negedge PCLK);
    end
  endtask

  task automatic waitIntr(input logic level);
    int n;
    n = 0;
    @(negedge PCLK);
    while (intr !== level) begin
      n++;
      if (n > WaitLimit) giveUp("intr change");
      @(negedge PCLK);
    end
  endtask

  //////////////////// serial line
  task automatic driveFrame(input uartLinePkg::frameCfgT cfg, input logic [7:0] value,
                            input logic badParity, input logic badStop);
    logic [11:0] bits;
    int          len, i;
    bits = frameBits(cfg, value);
    len  = frameLen(cfg);
    if (badParity && cfg.parityEn) bits[dataBits(cfg) + 1] = ~bits[dataBits(cfg) + 1];
    if (badStop) bits[dataBits(cfg) + 1 + int'(cfg.parityEn)] = 1'b0;
    @(posedge PCLK);
    #(DriveDly);
    for (i = 0; i <= len; i++) begin                         // plus one idle bit
      sin = (i < len) ? bits[i] : 1'b1;
      repeat (BitCycles) @(posedge PCLK);
      #(DriveDly);
    end
  endtask

  // finds the start edge on sout, then samples each bit in its middle
  task automatic checkTxFrame(input uartLinePkg::frameCfgT cfg, input logic [7:0] value);
    logic [11:0] exp;
    int          len, n, i;
    exp = frameBits(cfg, value);
    len = frameLen(cfg);
    n   = 0;
    @(negedge PCLK);
    while (sout !== 1'b0) begin
      n++;
      if (n > WaitLimit) giveUp("start bit on sout");
      @(negedge PCLK);
    end
    repeat (BitCycles / 2) @(negedge PCLK);
    for (i = 0; i < len; i++) begin
      checkBit($sformatf("sout bit %0d", i), sout, exp[i]);
      if (i < len - 1) repeat (BitCycles) @(negedge PCLK);
    end
  endtask

  //////////////////// tests
  initial begin : stimulus
    uartLinePkg::frameCfgT cfg8N1, cfg5O2, cfg7E1, cfg8E1;
    logic [7:0]            sent [17];
    int                    i;
    PRESETn = 1'b0;
    addr    = uartRegPkg::regRbr;
    din     = '0;
    memRdb  = 1'b1;
    memWrb  = 1'b1;
    sin     = 1'b1;                                          // line idles at mark
    cfg8N1  = '{wordLen: 2'd3, parityEn: 1'b0, evenParity: 1'b0, twoStop: 1'b0};
    cfg5O2  = '{wordLen: 2'd0, parityEn: 1'b1, evenParity: 1'b0, twoStop: 1'b1};
    cfg7E1  = '{wordLen: 2'd2, parityEn: 1'b1, evenParity: 1'b1, twoStop: 1'b0};
    cfg8E1  = '{wordLen: 2'd3, parityEn: 1'b1, evenParity: 1'b1, twoStop: 1'b0};
    repeat (10) @(posedge PCLK);
    #(DriveDly);
    PRESETn = 1'b1;

    expectReg(uartRegPkg::regLcr, `UART_LCR_RESET);
    expectReg(uartRegPkg::regLsr, lsrExpect(0, 0, 0, 0, 0));
    expectReg(uartRegPkg::regIir, `UART_IIR_NONE);
    checkBit("intr", intr, 1'b0);
    endTest("reset values");

    setFormat(cfg8N1);
    writeReg(uartRegPkg::regMcr, 8'h10);                     // loopback on
    for (i = 0; i < 16; i++) begin
      sent[i] = 8'($random(seed));
      writeReg(uartRegPkg::regRbr, sent[i]);
    end
    for (i = 0; i < 16; i++) begin
      waitLsrBit(0, "lsr data ready");
      popEntry(expectRx(cfg8N1, sent[i], 1'b0, 1'b0));
    end
    waitLsrBit(6, "transmitter empty");
    expectReg(uartRegPkg::regLsr, lsrExpect(0, 0, 0, 0, 0));
    writeReg(uartRegPkg::regMcr, 8'h00);
    endTest("loopback 8N1");

    setFormat(cfg5O2);
    sent[0] = 8'($random(seed));
    writeReg(uartRegPkg::regRbr, sent[0]);
    checkTxFrame(cfg5O2, sent[0]);
    waitLsrBit(6, "transmitter empty");
    setFormat(cfg7E1);
    sent[1] = 8'($random(seed));
    writeReg(uartRegPkg::regRbr, sent[1]);
    checkTxFrame(cfg7E1, sent[1]);
    waitLsrBit(6, "transmitter empty");
    endTest("transmit framing");

    setFormat(cfg8E1);
    writeReg(uartRegPkg::regIer, 8'h04);                     // line status only
    sent[0] = 8'($random(seed));
    sent[1] = 8'($random(seed));
    driveFrame(cfg8E1, sent[0], 1'b1, 1'b0);                 // parity flipped
    waitIntr(1'b1);
    driveFrame(cfg8E1, sent[1], 1'b0, 1'b1);                 // stop bit low
    waitRxCount(2);
    expectReg(uartRegPkg::regIir, `UART_IIR_LINE);
    expectReg(uartRegPkg::regLsr, lsrExpect(1, 1, 1, 0, 1));
    expectReg(uartRegPkg::regIir, `UART_IIR_NONE);
    expectReg(uartRegPkg::regLsr, lsrExpect(0, 0, 0, 0, 1)); // sticky bits gone
    popEntry(expectRx(cfg8E1, sent[0], 1'b1, 1'b0));
    popEntry(expectRx(cfg8E1, sent[1], 1'b0, 1'b1));
    endTest("receive errors");

    setFormat(cfg8N1);
    writeReg(uartRegPkg::regIir, 8'h46);                     // fcr: trigger 4, flush both
    writeReg(uartRegPkg::regIer, 8'h01);
    for (i = 0; i < 4; i++) begin
      sent[i] = 8'($random(seed));
      driveFrame(cfg8N1, sent[i], 1'b0, 1'b0);
      waitRxCount(i + 1);
      repeat (2) @(negedge PCLK);                            // intr is registered
      checkBit($sformatf("intr after frame %0d", i + 1), intr, i == 3);
    end
    expectReg(uartRegPkg::regIir, `UART_IIR_RXAVAIL);
    popEntry(expectRx(cfg8N1, sent[0], 1'b0, 1'b0));
    expectReg(uartRegPkg::regIir, `UART_IIR_NONE);
    for (i = 1; i < 4; i++) popEntry(expectRx(cfg8N1, sent[i], 1'b0, 1'b0));
    writeReg(uartRegPkg::regIer, 8'h00);
    endTest("receive trigger");

    for (i = 0; i < 17; i++) begin
      sent[i] = 8'($random(seed));
      driveFrame(cfg8N1, sent[i], 1'b0, 1'b0);
      if (i < 16) waitRxCount(i + 1);                        // 17th has nowhere to go
    end
    expectReg(uartRegPkg::regLsr, lsrExpect(0, 0, 0, 1, 1));
    for (i = 0; i < 16; i++) popEntry(expectRx(cfg8N1, sent[i], 1'b0, 1'b0));
    expectReg(uartRegPkg::regLsr, lsrExpect(0, 0, 0, 0, 0));
    endTest("overrun");

    allDone = 1'b1;
  end

  initial begin : finisher
    wait (hung || allDone);
    $display("tests %0d, checks %0d, errors %0d", testNum, checks, errors);
    if (!hung && errors == 0) $display("** PASS **");
    else $display("** FAIL **");
    $finish;
  end

endmodule

/* hdl/uartTop.sv */
// 16550-style UART top level. Tx and rx share one baud tick.
// In loopback the sout pin holds 1 and sin is ignored.
`timescale 1ns/100ps

module uartTop (
  input  logic                PCLK,
  input  logic                PRESETn,
  input  uartRegPkg::regAddrT addr,
  input  uartRegPkg::regByteT din,
  output uartRegPkg::regByteT dout,
  input  logic                memRdb,
  input  logic                memWrb,
  output logic                intr,
  input  logic                sin,
  output logic                sout
);

  uartLinePkg::frameCfgT  frameCfg;
  uartRegPkg::divisorT    divisor;
  logic                   divLoad, tick;
  logic                   txPush, txFlush, txEmpty, txIdle, soutBit;
  logic [7:0]             txData;
  logic                   rxPop, rxFlush, rxDone, loop, rxIn;
  uartLinePkg::rxEntryT   rxHead, rxFrame;
  uartLinePkg::fifoCountT rxCount;

  uartRegFile regFile (
    .PCLK, .PRESETn, .addr, .din, .memRdb, .memWrb,
    .rxHead, .rxCount, .rxDone, .rxFrame, .txEmpty, .txIdle,
    .dout, .frameCfg, .divisor, .divLoad, .txPush, .txData,
    .rxPop, .txFlush, .rxFlush, .loop, .intr
  );

  uartBaudGen baudGen (.PCLK, .PRESETn, .divisor, .divLoad, .tick);

  uartTx tx (
    .PCLK, .PRESETn, .tick, .frameCfg, .txPush, .txData, .txFlush,
    .txEmpty, .txIdle, .soutBit
  );

  // loopback feeds the shifter output straight back to the receiver
  assign rxIn = loop ? soutBit : sin;
  assign sout = loop ? 1'b1 : soutBit;    // pin parked at mark in loopback

  uartRx rx (
    .PCLK, .PRESETn, .tick, .frameCfg, .serialIn(rxIn), .rxPop, .rxFlush,
    .rxHead, .rxCount, .rxDone, .rxFrame
  );

endmodule

/* hdl/uartRx.sv */
// Receiver, 16x oversampled with a mid-bit sample. Only the first stop bit is checked.
// A start bit that reads high at mid-bit is dropped as noise.
`timescale 1ns/100ps
`include "uartDefs_defs.svh"

module uartRx (
  input  logic                   PCLK,
  input  logic                   PRESETn,
  input  logic                   tick,
  input  uartLinePkg::frameCfgT  frameCfg,
  input  logic                   serialIn,
  input  logic                   rxPop,
  input  logic                   rxFlush,
  output uartLinePkg::rxEntryT   rxHead,
  output uartLinePkg::fifoCountT rxCount,
  output logic                   rxDone,
  output uartLinePkg::rxEntryT   rxFrame
);

  localparam int Depth = `UART_FIFO_DEPTH;
  localparam uartLinePkg::fifoCountT Full = `UART_FIFO_DEPTH;

  logic                     syncA, syncB;        // 2-flop synchronizer
  uartLinePkg::shiftStateT  state;
  logic [3:0]               ovsCnt, bitIdx, lastIdx, numData;
  logic [9:1]               rxBits;              // data and parity, start not kept
  logic [7:0]               dataBits;
  logic                     parityBit, sampleNow, frameEnd;
  uartLinePkg::rxEntryT     newEntry;

  uartLinePkg::rxEntryT     fifoMem [Depth];
  logic [`UART_FIFO_AW-1:0] head, tail;
  uartLinePkg::fifoCountT   count;
  logic                     doPush, doPop;

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      syncA <= 1'b1;
      syncB <= 1'b1;
    end else begin
      syncA <= serialIn;
      syncB <= syncA;
    end
  end

  //////////////////// bit timing
  assign sampleNow = (state == uartLinePkg::shActive) && tick &&
                     (ovsCnt == 4'(`UART_OVERSAMPLE / 2 - 1));   // 8th tick of the bit
  assign lastIdx   = numData + 4'd1 + {3'b0, frameCfg.parityEn}; // stop bit position
  assign frameEnd  = sampleNow && (bitIdx == lastIdx);

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      state  <= uartLinePkg::shIdle;
      ovsCnt <= '0;
      bitIdx <= '0;
      rxDone <= 1'b0;
    end else begin
      rxDone <= frameEnd;
      case (state)
        uartLinePkg::shIdle: if (!syncB) begin   // falling edge, start bit
          state  <= uartLinePkg::shActive;
          ovsCnt <= '0;
          bitIdx <= '0;
        end
        uartLinePkg::shActive: begin
          if (tick) ovsCnt <= ovsCnt + 1'b1;
          if (sampleNow) begin
            bitIdx <= bitIdx + 1'b1;
            if (bitIdx == 4'd0 && syncB) state <= uartLinePkg::shIdle;  // glitch
            else if (frameEnd)           state <= uartLinePkg::shDone;
          end
        end
        // a low stop bit must clear before the next start is armed
        default: if (syncB) state <= uartLinePkg::shIdle;
      endcase
    end
  end

  //////////////////// frame check
  always_comb begin
    numData             = 4'd5 + {2'b00, frameCfg.wordLen};
    dataBits            = rxBits[8:1] & (8'hff >> (2'd3 - frameCfg.wordLen));
    parityBit           = rxBits[numData + 4'd1];
    newEntry.overrun    = (count == Full);       // no room, frame is dropped
    newEntry.parityErr  = frameCfg.parityEn && (^dataBits ^ parityBit ^ ~frameCfg.evenParity);
    newEntry.framingErr = !syncB;                // stop sampled this cycle
    newEntry.data       = dataBits;
  end

  always_ff @(posedge PCLK) begin
    if (sampleNow && bitIdx != 4'd0 && !frameEnd) rxBits[bitIdx] <= syncB;
    if (frameEnd) rxFrame <= newEntry;
  end

  //////////////////// fifo
  assign doPush = frameEnd && (count != Full);
  assign doPop  = rxPop && (count != '0);        // pop on empty ignored

  always_ff @(posedge PCLK) begin
    if (doPush) fifoMem[head] <= newEntry;
  end

  always_ff @(posedge PCLK) begin
    if (!PRESETn || rxFlush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (doPush) head <= head + 1'b1;
      if (doPop)  tail <= tail + 1'b1;
      count <= count + uartLinePkg::fifoCountT'(doPush) - uartLinePkg::fifoCountT'(doPop);
    end
  end

  assign rxHead  = (count == '0) ? '0 : fifoMem[tail];
  assign rxCount = count;

  doneAfterActive: assert property (@(posedge PCLK) disable iff (!PRESETn)
    rxDone |-> (state == uartLinePkg::shDone) && ($past(state) == uartLinePkg::shActive));

endmodule

/* hdl/uartTx.sv */
// Transmit FIFO and shifter. A push into a full FIFO is lost. The start bit
// is not tick aligned, so it may run up to one tick short.
`timescale 1ns/100ps
`include "uartDefs_defs.svh"

module uartTx (
  input  logic                  PCLK,
  input  logic                  PRESETn,
  input  logic                  tick,
  input  uartLinePkg::frameCfgT frameCfg,
  input  logic                  txPush,
  input  logic [7:0]            txData,
  input  logic                  txFlush,
  output logic                  txEmpty,
  output logic                  txIdle,
  output logic                  soutBit
);

  localparam int Depth = `UART_FIFO_DEPTH;
  localparam uartLinePkg::fifoCountT Full = `UART_FIFO_DEPTH;

  logic [7:0]               fifoMem [Depth];
  logic [`UART_FIFO_AW-1:0] head, tail;
  uartLinePkg::fifoCountT   count;
  logic                     doPush, doLoad;

  uartLinePkg::shiftStateT  state;
  logic [11:0]              shiftReg, frame;     // lsb goes out first
  logic [3:0]               ovsCnt, bitsLeft, frameLen, numData;
  logic [7:0]               curByte;
  logic                     parityBit, bitEnd;

  //////////////////// fifo
  assign doPush  = txPush && (count != Full);
  assign doLoad  = (state == uartLinePkg::shIdle) && (count != '0);
  assign txEmpty = (count == '0);
  assign txIdle  = txEmpty && (state == uartLinePkg::shIdle);

  always_ff @(posedge PCLK) begin
    if (doPush) fifoMem[head] <= txData;
  end

  always_ff @(posedge PCLK) begin
    if (!PRESETn || txFlush) begin        // flush leaves a frame in flight alone
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (doPush) head <= head + 1'b1;
      if (doLoad) tail <= tail + 1'b1;
      count <= count + uartLinePkg::fifoCountT'(doPush) - uartLinePkg::fifoCountT'(doLoad);
    end
  end

  //////////////////// frame builder
  always_comb begin
    numData   = 4'd5 + {2'b00, frameCfg.wordLen};
    curByte   = fifoMem[tail] & (8'hff >> (2'd3 - frameCfg.wordLen));  // mask to word length
    parityBit = ^curByte ^ ~frameCfg.evenParity;
    frame     = '1;                       // stop bits and idle padding
    frame[0]  = 1'b0;                     // start
    for (int i = 0; i < 8; i++) begin
      if (i < int'(numData)) frame[i+1] = curByte[i];
    end
    if (frameCfg.parityEn) frame[numData + 4'd1] = parityBit;
    // start + data + parity + 1 or 2 stop
    frameLen  = numData + 4'd2 + {3'b0, frameCfg.parityEn} + {3'b0, frameCfg.twoStop};
  end

  //////////////////// shifter
  assign bitEnd = tick && (ovsCnt == 4'(`UART_OVERSAMPLE - 1));

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      state    <= uartLinePkg::shIdle;
      shiftReg <= '1;                     // line idles high
      ovsCnt   <= '0;
      bitsLeft <= '0;
    end else begin
      case (state)
        uartLinePkg::shIdle: if (doLoad) begin
          shiftReg <= frame;
          ovsCnt   <= '0;
          bitsLeft <= frameLen;           // cfg latched with the frame
          state    <= uartLinePkg::shActive;
        end
        uartLinePkg::shActive: begin
          if (tick) ovsCnt <= ovsCnt + 1'b1;
          if (bitEnd) begin
            shiftReg <= {1'b1, shiftReg[11:1]};
            bitsLeft <= bitsLeft - 1'b1;
            if (bitsLeft == 4'd1) state <= uartLinePkg::shDone;
          end
        end
        default: state <= uartLinePkg::shIdle;   // done lasts one cycle
      endcase
    end
  end

  assign soutBit = shiftReg[0];

  fifoBound: assert property (@(posedge PCLK) disable iff (!PRESETn)
    count <= Full);

endmodule

/* hdl/uartBaudGen.sv */
// 16x oversample tick from the divisor latch. A divisor below 2 gives a stuck-high tick.
`timescale 1ns/100ps
`include "uartDefs_defs.svh"

module uartBaudGen (
  input  logic                PCLK,
  input  logic                PRESETn,
  input  uartRegPkg::divisorT divisor,
  input  logic                divLoad,     // restart on latch write
  output logic                tick
);

  localparam int CntW = 16 + `UART_PRESCALE;

  logic [CntW-1:0] count, limit;
  logic            hit;

  assign limit = CntW'(divisor) << `UART_PRESCALE;   // divisor * 2^prescale
  assign hit   = (count == limit);

  // count runs 1..limit, tick registered off the match
  always_ff @(posedge PCLK) begin
    if (!PRESETn || divLoad) begin
      count <= CntW'(1);
      tick  <= 1'b0;
    end else begin
      tick  <= hit;
      count <= hit ? CntW'(1) : count + 1'b1;
    end
  end

  tickOneCycle: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (tick && divisor > 16'd1) |=> !tick);

endmodule

/* hdl/uartRegFile.sv */
// Register map, line status and interrupt identity. The FIFOs are always on,
// so FCR bit 0 is ignored. Only MCR bit 4 (loopback) is kept.
`timescale 1ns/100ps
`include "uartDefs_defs.svh"

module uartRegFile (
  input  logic                   PCLK,
  input  logic                   PRESETn,
  input  uartRegPkg::regAddrT    addr,
  input  uartRegPkg::regByteT    din,
  input  logic                   memRdb,      // active low, one cycle
  input  logic                   memWrb,      // active low, one cycle
  input  uartLinePkg::rxEntryT   rxHead,
  input  uartLinePkg::fifoCountT rxCount,
  input  logic                   rxDone,
  input  uartLinePkg::rxEntryT   rxFrame,
  input  logic                   txEmpty,
  input  logic                   txIdle,
  output uartRegPkg::regByteT    dout,
  output uartLinePkg::frameCfgT  frameCfg,
  output uartRegPkg::divisorT    divisor,
  output logic                   divLoad,
  output logic                   txPush,
  output logic [7:0]             txData,
  output logic                   rxPop,
  output logic                   txFlush,
  output logic                   rxFlush,
  output logic                   loop,
  output logic                   intr
);

  uartRegPkg::lcrT        lcr;
  uartRegPkg::ierT        ier;
  uartRegPkg::lsrT        lsr;
  logic [1:0]             trigSel;              // fcr[7:6]
  uartLinePkg::fifoCountT trigLevel;
  logic                   wrEn, rdEn, dlab;
  logic                   lsrRead, iirRead;
  logic                   oeFlag, peFlag, feFlag, fifoErrFlag;
  logic                   threSquash;
  logic                   lineIp, rxIp, threIp;
  uartRegPkg::regByteT    iirVal;

  //////////////////// bus decode
  assign wrEn    = !memWrb;
  assign rdEn    = !memRdb;
  assign dlab    = lcr.dlab;
  assign divLoad = wrEn && dlab && (addr == uartRegPkg::regRbr || addr == uartRegPkg::regIer);
  assign txPush  = wrEn && !dlab && (addr == uartRegPkg::regRbr);   // thr write
  assign txData  = din;
  assign txFlush = wrEn && (addr == uartRegPkg::regIir) && din[2];  // fcr self-clearing bits
  assign rxFlush = wrEn && (addr == uartRegPkg::regIir) && din[1];
  assign rxPop   = rdEn && !dlab && (addr == uartRegPkg::regRbr);   // rbr read pops
  assign lsrRead = rdEn && (addr == uartRegPkg::regLsr);
  assign iirRead = rdEn && (addr == uartRegPkg::regIir);

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      lcr     <= `UART_LCR_RESET;
      ier     <= '0;
      trigSel <= '0;
      loop    <= 1'b0;
      divisor <= `UART_DIV_RESET;
    end else if (wrEn) begin
      case (addr)
        uartRegPkg::regRbr: if (dlab) divisor[7:0] <= din;
        uartRegPkg::regIer: begin
          if (dlab) divisor[15:8] <= din;
          else      ier <= din[3:0];
        end
        uartRegPkg::regIir: trigSel <= din[7:6];  // fcr, flush bits act as pulses
        uartRegPkg::regLcr: lcr <= din;
        uartRegPkg::regMcr: loop <= din[4];
        default: ;                                // lsr/msr/scr writes ignored
      endcase
    end
  end

  assign frameCfg = '{wordLen: lcr.wordLen, parityEn: lcr.parityEn,
                      evenParity: lcr.evenParity, twoStop: lcr.twoStop};

  //////////////////// line status
  // a new error in the same cycle as an lsr read survives the clear
  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      oeFlag      <= 1'b0;
      peFlag      <= 1'b0;
      feFlag      <= 1'b0;
      fifoErrFlag <= 1'b0;
    end else begin
      oeFlag      <= (oeFlag && !lsrRead) || (rxDone && rxFrame.overrun);
      peFlag      <= (peFlag && !lsrRead) || (rxDone && rxFrame.parityErr);
      feFlag      <= (feFlag && !lsrRead) || (rxDone && rxFrame.framingErr);
      fifoErrFlag <= (fifoErrFlag && !lsrRead && !rxFlush) ||
                     (rxDone && !rxFrame.overrun && (rxFrame.parityErr || rxFrame.framingErr));
    end
  end

  always_comb begin
    lsr            = '0;                // break bit stays 0
    lsr.fifoErr    = fifoErrFlag;       // errored entry went into the fifo
    lsr.temt       = txIdle;
    lsr.thre       = txEmpty;
    lsr.framingErr = feFlag;
    lsr.parityErr  = peFlag;
    lsr.overrunErr = oeFlag;
    lsr.dataReady  = (rxCount != '0);
  end

  //////////////////// interrupts
  always_comb begin
    case (trigSel)
      2'd0:    trigLevel = 5'd1;
      2'd1:    trigLevel = 5'd4;
      2'd2:    trigLevel = 5'd8;
      default: trigLevel = 5'd14;
    endcase
  end

  assign lineIp = ier.lineEn && (oeFlag || peFlag || feFlag);
  assign rxIp   = ier.rxAvailEn && (rxCount >= trigLevel);
  assign threIp = ier.threEn && txEmpty && !threSquash;

  always_comb begin
    if (lineIp)      iirVal = `UART_IIR_LINE;      // highest priority
    else if (rxIp)   iirVal = `UART_IIR_RXAVAIL;
    else if (threIp) iirVal = `UART_IIR_THRE;
    else             iirVal = `UART_IIR_NONE;
  end

  // reading iir while thre is reported hides it until the next push
  always_ff @(posedge PCLK) begin
    if (!PRESETn)                                  threSquash <= 1'b0;
    else if (txPush)                               threSquash <= 1'b0;
    else if (iirRead && iirVal == `UART_IIR_THRE)  threSquash <= 1'b1;
  end

  always_ff @(posedge PCLK) begin
    if (!PRESETn) intr <= 1'b0;
    else          intr <= (iirVal != `UART_IIR_NONE);   // registered, one cycle behind iir
  end

  //////////////////// read mux
  always_comb begin
    dout = '0;
    if (rdEn) begin
      case (addr)
        uartRegPkg::regRbr: dout = dlab ? divisor[7:0] : rxHead.data;
        uartRegPkg::regIer: dout = dlab ? divisor[15:8] : {4'b0, ier};
        uartRegPkg::regIir: dout = iirVal;
        uartRegPkg::regLcr: dout = lcr;
        uartRegPkg::regMcr: dout = {3'b0, loop, 4'b0};
        uartRegPkg::regLsr: dout = lsr;
        default:            dout = '0;             // msr, scr not present
      endcase
    end
  end

  // the cpu side issues one access at a time
  busExclusive: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !(rdEn && wrEn));

endmodule

/* hdl/uartLinePkg.sv */
// Serial-line types shared by the transmitter, the receiver and the register file.
`include "uartDefs_defs.svh"
package uartLinePkg;

  // the part of LCR the shifters care about
  typedef struct packed {
    logic [1:0] wordLen;            // 0..3 -> 5..8 data bits
    logic       parityEn;
    logic       evenParity;
    logic       twoStop;
  } frameCfgT;

  // one received character, data right aligned and masked to word length
  typedef struct packed {
    logic       overrun;
    logic       parityErr;
    logic       framingErr;
    logic [7:0] data;
  } rxEntryT;

  typedef logic [`UART_FIFO_AW:0] fifoCountT;   // 0..depth inclusive

  // common to tx and rx shifters
  typedef enum logic [1:0] {
    shIdle,
    shActive,
    shDone
  } shiftStateT;

endpackage

/* hdl/uartRegPkg.sv */
// CPU-side register types for the 16550-style register map.
// MSR and SCR addresses exist in the map but read as zero.
package uartRegPkg;

  typedef logic [7:0]  regByteT;    // bus data byte
  typedef logic [15:0] divisorT;    // {DLM, DLL}

  typedef enum logic [2:0] {
    regRbr = 3'd0,                  // rbr / thr, dll when dlab
    regIer = 3'd1,                  // ier, dlm when dlab
    regIir = 3'd2,                  // iir read, fcr write
    regLcr = 3'd3,
    regMcr = 3'd4,
    regLsr = 3'd5,
    regMsr = 3'd6,                  // not implemented
    regScr = 3'd7                   // not implemented
  } regAddrT;

  typedef struct packed {
    logic       dlab;               // divisor latch access
    logic       brk;                // stored only, no break output
    logic       stickParity;        // stored only
    logic       evenParity;
    logic       parityEn;
    logic       twoStop;
    logic [1:0] wordLen;            // 0..3 -> 5..8 bits
  } lcrT;

  typedef struct packed {
    logic modemEn;                  // no modem source, stored only
    logic lineEn;
    logic threEn;
    logic rxAvailEn;
  } ierT;

  typedef struct packed {
    logic fifoErr;
    logic temt;
    logic thre;
    logic brk;                      // always 0
    logic framingErr;
    logic parityErr;
    logic overrunErr;
    logic dataReady;
  } lsrT;

endpackage

/* hdl/uartDefs_defs.svh */
// UART build constants. The tick period is divisor << UART_PRESCALE cycles.
// The FIFO depth and the pointer width must agree (depth = 2**aw).
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

`define UART_PRESCALE    0          // extra divide bits ahead of the divisor latch
`define UART_FIFO_DEPTH  16         // entries per fifo
`define UART_FIFO_AW     4          // fifo pointer width
`define UART_OVERSAMPLE  16         // ticks per serial bit

`define UART_LCR_RESET   8'h03      // 8 data bits, 1 stop, no parity
`define UART_DIV_RESET   16'd1      // smallest legal latch value

// iir read values, lowest bit set means nothing pending
`define UART_IIR_NONE    8'h01
`define UART_IIR_LINE    8'h06
`define UART_IIR_RXAVAIL 8'h04
`define UART_IIR_THRE    8'h02

`endif
